// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_engine_pipeline
LINT_TOP   ?= engine_pipeline_top
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := Regression failed
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/engine_cfg_pkg.sv
// Configuration constants of the engine stage
// FIFO depth and programmable-full threshold
// Delay line depth, packet field widths, counter width

package engine_cfg_pkg;

    // ----------------------------------------
    // FIFO sizing
    // ----------------------------------------
    localparam int unsigned fifo_depth       = 16;
    localparam int unsigned prog_thresh      = 8;
    localparam int unsigned fifo_count_width = 5;

    // Fixed latency of the delay line in each lane
    localparam int unsigned pipeline_stages  = 2;

    // Keep prog_thresh + pipeline_stages + 2 <= fifo_depth so the output FIFO
    // can take every packet still in flight once its prog_full rises

    // ----------------------------------------
    // Packet fields
    // ----------------------------------------
    localparam int unsigned meta_width       = 16;
    localparam int unsigned data_width       = 32;

endpackage : engine_cfg_pkg

// File: logic/engine_pipeline_top.sv
// Top level of the engine stage
// Registered reset copy for the internal logic
// Engine lane and memory lane
// Done flag from both lane idle signals

`timescale 1ns/10ps

module engine_pipeline_top
    import engine_types_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_template_engine,
    input  packet_t      engine_in,
    input  packet_t      memory_in,
    input  lane_ctrl_t   engine_ctrl,
    input  lane_ctrl_t   memory_ctrl,
    output packet_t      engine_out,
    output packet_t      memory_out,
    output lane_status_t engine_status,
    output lane_status_t memory_status,
    output logic         done_out
);

    logic areset_reg;
    logic engine_idle;
    logic memory_idle;

    // Internal reset trails the port by one cycle
    always_ff @(posedge ap_clk) begin
        areset_reg <= areset_template_engine;
    end

    // ----------------------------------------
    // Lanes
    // ----------------------------------------

    // Engine responses in, engine requests out
    packet_lane u_engine_lane (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_reg),
        .pkt_in                 (engine_in),
        .ctrl                   (engine_ctrl),
        .pkt_out                (engine_out),
        .status                 (engine_status),
        .idle                   (engine_idle)
    );

    // Memory responses in, memory requests out
    packet_lane u_memory_lane (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_reg),
        .pkt_in                 (memory_in),
        .ctrl                   (memory_ctrl),
        .pkt_out                (memory_out),
        .status                 (memory_status),
        .idle                   (memory_idle)
    );

    // ----------------------------------------
    // Done
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_reg) begin
            done_out <= 1'b0;
        end else begin
            done_out <= engine_idle & memory_idle;
        end
    end

endmodule : engine_pipeline_top

// File: logic/engine_types_pkg.sv
// Packed struct types shared by the engine stage
// Packet payload and valid-tagged packet
// Per-lane control inputs and registered status flags

package engine_types_pkg;

    import engine_cfg_pkg::*;

    // ----------------------------------------
    // Packets
    // ----------------------------------------

    // Routing metadata plus vertex data, 48 bits
    typedef struct packed {
        logic [meta_width-1:0] meta;
        logic [data_width-1:0] data;
    } packet_payload_t;

    // Payload with its valid strobe, 49 bits
    typedef struct packed {
        logic            valid;
        packet_payload_t payload;
    } packet_t;

    // ----------------------------------------
    // Lane control and status
    // ----------------------------------------

    // Downstream permission to drain the input FIFO, and output pop level
    typedef struct packed {
        logic drain_en;
        logic pop_en;
    } lane_ctrl_t;

    // FIFO flags as seen from outside, one cycle late
    typedef struct packed {
        logic in_empty;
        logic in_prog_full;
        logic out_empty;
        logic out_prog_full;
    } lane_status_t;

endpackage : engine_types_pkg

// File: logic/packet_fifo.sv
// Synchronous FIFO for packet payloads
// Circular buffer with read and write pointers and an occupancy counter
// Registered read data with a valid strobe
// Full, empty and programmable-full flags from the counter

`timescale 1ns/10ps

module packet_fifo
    import engine_cfg_pkg::*;
    import engine_types_pkg::*;
#(
    parameter int unsigned depth  = fifo_depth,
    parameter int unsigned thresh = prog_thresh
) (
    input  logic            ap_clk,
    input  logic            areset_template_engine,
    input  logic            wr_en,
    input  packet_payload_t din,
    input  logic            rd_en,
    output packet_payload_t dout,
    output logic            valid,
    output logic            empty,
    output logic            full,
    output logic            prog_full
);

    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------
    packet_payload_t             mem [depth];
    logic [ptr_w-1:0]            wr_ptr;
    logic [ptr_w-1:0]            rd_ptr;
    logic [fifo_count_width-1:0] count;

    logic do_write;
    logic do_read;

    // Wrap at depth so non power of two sizes also work
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Requests that would over- or underflow are ignored
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & ~empty;

    // ----------------------------------------
    // Flags
    // ----------------------------------------
    assign empty     = (count == '0);
    assign full      = (count == fifo_count_width'(depth));
    assign prog_full = (count >= fifo_count_width'(thresh));

    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointer and occupancy bookkeeping
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            valid <= 1'b0;
        end else begin
            valid <= do_read;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_read) begin
            dout <= mem[rd_ptr];
        end
    end

    // Upstream must have paused on prog_full well before this
    assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        !(wr_en && full))
        else $error("packet_fifo: write while full, packet dropped");

    assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        !(rd_en && empty))
        else $error("packet_fifo: read while empty");

endmodule : packet_fifo

// File: logic/packet_lane.sv
// One packet lane of the engine stage
// Input register, input FIFO and gated drain
// Delay line into the output FIFO, popped packet register
// Registered status flags and lane idle

`timescale 1ns/10ps

module packet_lane
    import engine_types_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_template_engine,
    input  packet_t      pkt_in,
    input  lane_ctrl_t   ctrl,
    output packet_t      pkt_out,
    output lane_status_t status,
    output logic         idle
);

    packet_t    pkt_reg;
    lane_ctrl_t ctrl_reg;

    packet_payload_t in_dout;
    logic            in_valid;
    logic            in_empty;
    logic            in_prog_full;
    logic            in_rd_en;

    packet_t fifo_pkt;
    packet_t dly_pkt;
    logic    dly_busy;

    packet_payload_t out_dout;
    logic            out_valid;
    logic            out_empty;
    logic            out_full;
    logic            out_prog_full;
    logic            out_rd_en;

    // ----------------------------------------
    // Input side
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            pkt_reg.valid <= 1'b0;
            ctrl_reg      <= '0;
        end else begin
            pkt_reg.valid <= pkt_in.valid;
            ctrl_reg      <= ctrl;
        end
    end

    always_ff @(posedge ap_clk) begin
        pkt_reg.payload <= pkt_in.payload;
    end

    // Drain only while the output FIFO still has slack
    assign in_rd_en = ~in_empty & ctrl_reg.drain_en & ~out_prog_full;

    packet_fifo u_in_fifo (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .wr_en                  (pkt_reg.valid),
        .din                    (pkt_reg.payload),
        .rd_en                  (in_rd_en),
        .dout                   (in_dout),
        .valid                  (in_valid),
        .empty                  (in_empty),
        .full                   (),
        .prog_full              (in_prog_full)
    );

    // ----------------------------------------
    // Delay line and output FIFO
    // ----------------------------------------
    assign fifo_pkt.valid   = in_valid;
    assign fifo_pkt.payload = in_dout;

    stage_delay_line u_delay (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .din                    (fifo_pkt),
        .dout                   (dly_pkt),
        .busy                   (dly_busy)
    );

    assign out_rd_en = ~out_empty & ctrl_reg.pop_en;

    packet_fifo u_out_fifo (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .wr_en                  (dly_pkt.valid),
        .din                    (dly_pkt.payload),
        .rd_en                  (out_rd_en),
        .dout                   (out_dout),
        .valid                  (out_valid),
        .empty                  (out_empty),
        .full                   (out_full),
        .prog_full              (out_prog_full)
    );

    // ----------------------------------------
    // Registered outputs
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            pkt_out.valid <= 1'b0;
            status        <= '{in_empty: 1'b1, in_prog_full: 1'b0,
                               out_empty: 1'b1, out_prog_full: 1'b0};
            idle          <= 1'b0;
        end else begin
            pkt_out.valid        <= out_valid;
            status.in_empty      <= in_empty;
            status.in_prog_full  <= in_prog_full;
            status.out_empty     <= out_empty;
            status.out_prog_full <= out_prog_full;
            // Also covers packets held in the registers between stages
            idle <= in_empty & out_empty & ~dly_busy
                    & ~pkt_reg.valid & ~in_valid & ~out_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        pkt_out.payload <= out_dout;
    end

    // Packets in flight after prog_full must fit in the remaining slack
    assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        !(dly_pkt.valid && out_full))
        else $error("packet_lane: delay line pushed into full output FIFO");

endmodule : packet_lane

// File: logic/stage_delay_line.sv
// Fixed-depth delay line for packets
// Register chain with reset valid bits and unreset payloads
// Busy flag while any stage holds a packet

`timescale 1ns/10ps

module stage_delay_line
    import engine_cfg_pkg::*;
    import engine_types_pkg::*;
#(
    parameter int unsigned stages = pipeline_stages
) (
    input  logic    ap_clk,
    input  logic    areset_template_engine,
    input  packet_t din,
    output packet_t dout,
    output logic    busy
);

    packet_t chain [stages];

    // Valid bits of the chain
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            for (int i = 0; i < stages; i++) begin
                chain[i].valid <= 1'b0;
            end
        end else begin
            chain[0].valid <= din.valid;
            for (int i = 1; i < stages; i++) begin
                chain[i].valid <= chain[i-1].valid;
            end
        end
    end

    // Payloads shift along unconditionally
    always_ff @(posedge ap_clk) begin
        chain[0].payload <= din.payload;
        for (int i = 1; i < stages; i++) begin
            chain[i].payload <= chain[i-1].payload;
        end
    end

    always_comb begin
        busy = 1'b0;
        for (int i = 0; i < stages; i++) begin
            busy = busy | chain[i].valid;
        end
    end

    assign dout = chain[stages-1];

endmodule : stage_delay_line

// File: testbench/tb_checks.svh
// Compare tasks for the engine stage testbench
// Packet payload, lane status and single bit checks
// Per-test bookkeeping and fault reporting

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_packet(input string name, input packet_payload_t got,
                            input packet_payload_t exp);
    if (got !== exp) begin
        $display("error %s got %h expected %h", name, got, exp);
        error_count++;
    end
endtask

task automatic check_status(input string name, input lane_status_t got,
                            input lane_status_t exp);
    if (got !== exp) begin
        $display("error %s got %h expected %h", name, got, exp);
        error_count++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("error %s got %h expected %h", name, got, exp);
        error_count++;
    end
endtask

// Failures that are not a value mismatch
task automatic report_fault(input string what);
    $display("%s", what);
    error_count++;
endtask

task automatic start_test(input string name);
    test_name        = name;
    errors_at_start  = error_count;
    test_count++;
endtask

task automatic finish_test();
    if (error_count == errors_at_start) begin
        $display("test %0d %s ok", test_count, test_name);
    end else begin
        $display("test %0d %s failed with %0d errors", test_count, test_name,
                 error_count - errors_at_start);
        failed_tests++;
    end
endtask

`endif

// File: testbench/tb_engine_pipeline.sv
// Testbench for the engine stage top level
// Clock, reset and a stimulus table applied in a loop
// Per-lane scoreboard queues checked by an output monitor
// Closing summary with test and error counts

`timescale 1ns/10ps

module tb_engine_pipeline
    import engine_cfg_pkg::*;
    import engine_types_pkg::*;
();

    // One table row with lanes to drive, meta, packet count, pop hold and back-pressure flag
    typedef struct packed {
        logic [1:0]            lanes;
        logic [meta_width-1:0] meta;
        int unsigned           count;
        int unsigned           hold;
        logic                  expect_bp;
    } stim_row_t;

    localparam int unsigned  num_rows     = 3;
    localparam int unsigned  loop_limit   = 300;
    localparam lane_status_t empty_status = '{in_empty: 1'b1, in_prog_full: 1'b0,
                                              out_empty: 1'b1, out_prog_full: 1'b0};

    logic         ap_clk;
    logic         areset_template_engine;
    packet_t      engine_in;
    packet_t      memory_in;
    lane_ctrl_t   engine_ctrl;
    lane_ctrl_t   memory_ctrl;
    packet_t      engine_out;
    packet_t      memory_out;
    lane_status_t engine_status;
    lane_status_t memory_status;
    logic         done_out;

    packet_payload_t exp_engine [$];
    packet_payload_t exp_memory [$];

    int          error_count     = 0;
    int          test_count      = 0;
    int          failed_tests    = 0;
    int          errors_at_start = 0;
    string       test_name;

    // Engine burst, both lanes together, then back-pressure with pop held low
    stim_row_t stim_table [num_rows] = '{
        '{2'b01, 16'h00e1, 5, 0, 1'b0},
        '{2'b11, 16'h0b07, 6, 0, 1'b0},
        '{2'b01, 16'h0c3a, 2 * (prog_thresh + pipeline_stages + 2), 40, 1'b1}
    };

    `include "tb_checks.svh"

    engine_pipeline_top i_dut (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .engine_in              (engine_in),
        .memory_in              (memory_in),
        .engine_ctrl            (engine_ctrl),
        .memory_ctrl            (memory_ctrl),
        .engine_out             (engine_out),
        .memory_out             (memory_out),
        .engine_status          (engine_status),
        .memory_status          (memory_status),
        .done_out               (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // ----------------------------------------
    // Output monitor and scoreboard
    // ----------------------------------------
    always @(negedge ap_clk) begin
        if (engine_out.valid === 1'b1) begin
            if (exp_engine.size() == 0) begin
                report_fault("unexpected packet on the engine lane");
            end else begin
                check_packet("engine_out", engine_out.payload, exp_engine.pop_front());
            end
        end
        if (memory_out.valid === 1'b1) begin
            if (exp_memory.size() == 0) begin
                report_fault("unexpected packet on the memory lane");
            end else begin
                check_packet("memory_out", memory_out.payload, exp_memory.pop_front());
            end
        end
    end

    // Wait for both queues to empty and done_out to be high
    task automatic wait_drained();
        int unsigned cycles;
        cycles = 0;
        @(negedge ap_clk);
        while (!(exp_engine.size() == 0 && exp_memory.size() == 0 && done_out === 1'b1)
               && cycles < loop_limit) begin
            @(negedge ap_clk);
            cycles++;
        end
        if (cycles >= loop_limit) begin
            report_fault($sformatf("timed out waiting for done, %0d engine and %0d memory left",
                                   exp_engine.size(), exp_memory.size()));
        end
    endtask

    // ----------------------------------------
    // One table row
    // ----------------------------------------
    task automatic run_row(input stim_row_t row);
        int unsigned sent;
        int unsigned cycle;
        logic        in_pf;
        logic        seen_out_pf;
        logic        seen_in_pf;
        logic        seen_done_low;
        packet_t     pkt;
        sent          = 0;
        cycle         = 0;
        seen_out_pf   = 1'b0;
        seen_in_pf    = 1'b0;
        seen_done_low = 1'b0;
        while ((sent < row.count || cycle < row.hold) && cycle < loop_limit) begin
            @(negedge ap_clk);
            in_pf = engine_status.in_prog_full | memory_status.in_prog_full;
            if (engine_status.out_prog_full || memory_status.out_prog_full) begin
                seen_out_pf = 1'b1;
            end
            // In-FIFO pressure only counts once the output side has backed up
            if (seen_out_pf && in_pf) begin
                seen_in_pf = 1'b1;
            end
            if (done_out !== 1'b1) begin
                seen_done_low = 1'b1;
            end
            @(posedge ap_clk);
            engine_ctrl.pop_en <= (cycle >= row.hold);
            memory_ctrl.pop_en <= (cycle >= row.hold);
            engine_in.valid    <= 1'b0;
            memory_in.valid    <= 1'b0;
            if (sent < row.count && !in_pf) begin
                if (row.lanes[0]) begin
                    pkt.valid        = 1'b1;
                    pkt.payload.meta = row.meta;
                    pkt.payload.data = $urandom();
                    exp_engine.push_back(pkt.payload);
                    engine_in <= pkt;
                end
                if (row.lanes[1]) begin
                    pkt.valid        = 1'b1;
                    pkt.payload.meta = row.meta ^ 16'h8000;
                    pkt.payload.data = $urandom();
                    exp_memory.push_back(pkt.payload);
                    memory_in <= pkt;
                end
                sent++;
            end
            cycle++;
        end
        if (cycle >= loop_limit) begin
            report_fault($sformatf("stimulus loop timed out after sending %0d packets", sent));
        end
        @(posedge ap_clk);
        engine_in.valid    <= 1'b0;
        memory_in.valid    <= 1'b0;
        engine_ctrl.pop_en <= 1'b1;
        memory_ctrl.pop_en <= 1'b1;
        wait_drained();
        check_bit("done_out_fell", seen_done_low, 1'b1);
        check_bit("out_prog_full_seen", seen_out_pf, row.expect_bp);
        check_bit("in_prog_full_seen", seen_in_pf, row.expect_bp);
        check_status("engine_status", engine_status, empty_status);
        check_status("memory_status", memory_status, empty_status);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h36bd));
        areset_template_engine = 1'b1;
        engine_in              = '0;
        memory_in              = '0;
        engine_ctrl            = '{drain_en: 1'b1, pop_en: 1'b1};
        memory_ctrl            = '{drain_en: 1'b1, pop_en: 1'b1};
        repeat (3) @(posedge ap_clk);
        areset_template_engine <= 1'b0;

        start_test("reset");
        wait_drained();
        check_bit("engine_out.valid", engine_out.valid, 1'b0);
        check_bit("memory_out.valid", memory_out.valid, 1'b0);
        check_status("engine_status", engine_status, empty_status);
        check_status("memory_status", memory_status, empty_status);
        finish_test();

        for (int i = 0; i < num_rows; i++) begin
            start_test($sformatf("row %0d", i));
            run_row(stim_table[i]);
            finish_test();
        end

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_engine_pipeline

// File: vlog.f
+incdir+testbench
logic/engine_cfg_pkg.sv
logic/engine_types_pkg.sv
logic/packet_fifo.sv
logic/stage_delay_line.sv
logic/packet_lane.sv
logic/engine_pipeline_top.sv
testbench/tb_engine_pipeline.sv
